/* compile.f */
spi_pkg.sv
spi_master_regs.sv
spi_master_fifo.sv
spi_master_ctrl.sv
spi_master_io.sv
spi_master.sv
tb_spi_master.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator, verdict from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_spi_master -f compile.f > sim.log 2>&1 &&
   ./obj_dir/Vtb_spi_master >> sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

/* tb_spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master;

   import spi_pkg::*;

   localparam int clkdiv_rst = 1;
   localparam int fifo_depth = 4;
   // 16 bytes at clkdiv 3 is about 1100 cycles, plus reads and polls
   localparam int max_cycles = 20000;

   logic          clk;
   logic          nreset;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_in;
   logic          miso;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_out;
   logic          sclk;
   logic          mosi;
   logic          ss_n;

   // expected reply, set by the read task
   string       test_name;
   logic [31:0] exp_data;
   logic [31:0] exp_dst;
   logic [4:0]  exp_ctrl;
   logic        chk_data;
   logic        cpol_exp;    // cpol as last written
   logic [63:0] rx_model;    // rx shift window
   logic [31:0] last_reply;
   logic        rd_q;        // read taken last edge
   logic        sclk_q;
   logic        cpol_q;
   int          cycles = 0;

   assign miso = mosi;  // loopback

   spi_master #(.CLKDIV(clkdiv_rst), .FIFO_DEPTH(fifo_depth)) i_spi_master (
      .clk, .nreset, .access_in, .packet_in, .wait_in, .miso, .access_out, .packet_out,
      .wait_out, .sclk, .mosi, .ss_n);

   always #10 clk = ~clk;

   //############################
   // helpers
   //############################

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic value_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run("reply carries a wrong value");
   endtask

   // newest byte enters at the bottom
   function automatic logic [63:0] shift_bytes(input logic [63:0] window,
                                               input logic [63:0] data, input int n);
      logic [63:0] w;
      w = window;
      for (int i = 0; i < n; i++)
         w = {w[55:0], data[8*i +: 8]};  // byte 0 goes out first
      return w;
   endfunction

   task automatic write_reg(input logic [5:0] off, input logic [1:0] mode,
                            input logic [63:0] value);
      packet_in.write      = 1'b1;
      packet_in.datamode   = mode;
      packet_in.ctrlmode   = 5'd0;
      packet_in.dstaddr    = {26'b0, off};
      packet_in.hi.data_hi = value[63:32];  // only used on 8-byte tx
      packet_in.data       = value[31:0];
      access_in            = 1'b1;
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic set_config(input logic [7:0] value);
      write_reg(spi_config, 2'd2, {56'b0, value});
      cpol_exp = value[1];  // config live since last posedge
   endtask

   task automatic send_word(input logic [1:0] mode, input logic [63:0] data);
      write_reg(spi_tx, mode, data);
      rx_model = shift_bytes(rx_model, data, 1 << mode);  // 1, 2, 4 or 8 bytes
   endtask

   task automatic read_reg(input string name, input logic [5:0] off, input logic [31:0] exp,
                           input logic check);
      test_name            = name;
      exp_data             = exp;
      chk_data             = check;
      exp_dst              = $urandom();
      exp_ctrl             = 5'($urandom());
      packet_in.write      = 1'b0;
      packet_in.datamode   = 2'd2;
      packet_in.ctrlmode   = exp_ctrl;
      packet_in.dstaddr    = {26'b0, off};
      packet_in.hi.srcaddr = exp_dst;
      packet_in.data       = 32'h0;
      access_in            = 1'b1;
      @(negedge clk);
      access_in = 1'b0;
      @(negedge clk);  // reply checked on the posedge between
   endtask

   // count words by slave select going high
   task automatic wait_words(input int n);
      int seen;
      seen = 0;
      while (seen < n)
      begin
         @(posedge ss_n);
         seen++;
      end
      @(negedge clk);
   endtask

   task automatic wait_idle();
      read_reg("busy poll", spi_status, 32'h0, 1'b0);
      while (last_reply[1])
         read_reg("busy poll", spi_status, 32'h0, 1'b0);
   endtask

   //############################
   // checkers
   //############################

   always @(posedge clk)
   begin
      rd_q   <= access_in & ~packet_in.write;
      sclk_q <= sclk;
      cpol_q <= cpol_exp;
      if (access_out)
         last_reply <= packet_out.data;  // kept for polling
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
         abort_run("timeout, the run did not finish in time");
   end

   reply_timing_a : assert property (@(posedge clk) disable iff (!nreset) access_out == rd_q)
      else abort_run("reply strobe not exactly one cycle after its read");
   reply_data_a : assert property (@(posedge clk) disable iff (!nreset)
      (access_out && chk_data) |-> (packet_out.data == exp_data))
      else value_mismatch(test_name, exp_data, packet_out.data);
   reply_dst_a : assert property (@(posedge clk) disable iff (!nreset)
      access_out |-> (packet_out.dstaddr == exp_dst))
      else value_mismatch({test_name, " dstaddr"}, exp_dst, packet_out.dstaddr);
   reply_hdr_a : assert property (@(posedge clk) disable iff (!nreset)
      access_out |-> (packet_out.write && packet_out.ctrlmode == exp_ctrl &&
                      packet_out.datamode == 2'd2))
      else abort_run("reply header does not match its read");
   idle_sclk_a : assert property (@(posedge clk) disable iff (!nreset)
      ss_n |-> (sclk == cpol_exp))
      else abort_run("sclk not at idle level while slave deselected");
   sclk_edge_a : assert property (@(posedge clk) disable iff (!nreset)
      ((sclk != sclk_q) && (cpol_exp == cpol_q)) |-> !ss_n)
      else abort_run("sclk edge while slave deselected");

   //############################
   // stimulus
   //############################

   initial
   begin
      void'($urandom(7883));
      clk       = 1'b0;
      nreset    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      cpol_exp  = 1'b0;
      chk_data  = 1'b0;
      rx_model  = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;

      read_reg("reset config", spi_config, 32'h0, 1'b1);
      read_reg("reset status", spi_status, 32'h0, 1'b1);
      read_reg("reset clkdiv", spi_clkdiv, 32'(clkdiv_rst), 1'b1);
      read_reg("reset rx0", spi_rx0, 32'h0, 1'b1);
      read_reg("unmapped", 6'h3c, 32'hdeadbeef, 1'b1);

      write_reg(spi_clkdiv, 2'd2, 64'd3);
      read_reg("clkdiv", spi_clkdiv, 32'd3, 1'b1);
      set_config(8'h08);  // lsb first
      read_reg("config lsb", spi_config, 32'h08, 1'b1);

      send_word(2'd3, 64'h0123_4567_89ab_cdef);
      wait_words(1);
      wait_idle();
      read_reg("rx0 eight bytes", spi_rx0, rx_model[31:0], 1'b1);
      read_reg("rx1 eight bytes", spi_rx1, rx_model[63:32], 1'b1);

      // sticky flag set, then cleared by a status write
      read_reg("status sticky", spi_status, 32'h01, 1'b1);
      write_reg(spi_status, 2'd2, 64'h0);
      read_reg("status cleared", spi_status, 32'h00, 1'b1);

      set_config(8'h06);  // msb first, cpol 1, cpha 1
      read_reg("config modes", spi_config, 32'h06, 1'b1);
      send_word(2'd2, 64'ha5c3_0f96);
      wait_words(1);
      wait_idle();
      read_reg("rx0 four bytes", spi_rx0, rx_model[31:0], 1'b1);
      read_reg("rx1 four bytes", spi_rx1, rx_model[63:32], 1'b1);

      // fill queue with spi off
      set_config(8'h09);
      for (int i = 0; i < fifo_depth; i++)
         send_word(2'd0, 64'(32'h11 * (i + 1)));
      assert (wait_out) else abort_run("wait_out low with the tx fifo full");
      @(negedge clk);  // status register picks up full one edge later
      read_reg("status full", spi_status, 32'h05, 1'b1);
      set_config(8'h08);
      wait_words(fifo_depth);
      wait_idle();
      assert (!wait_out) else abort_run("wait_out still high after the fifo drained");
      read_reg("status drained", spi_status, 32'h01, 1'b1);
      read_reg("rx0 drained", spi_rx0, rx_model[31:0], 1'b1);
      read_reg("rx1 drained", spi_rx1, rx_model[63:32], 1'b1);

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* spi_master.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master
  #(parameter int CLKDIV     = 1,
    parameter int FIFO_DEPTH = 4)
   (
   input  wire                          clk,
   input  wire                          nreset,
   input  wire                          access_in,
   input  wire spi_pkg::emesh_packet_t  packet_in,
   input  wire                          wait_in,
   input  wire                          miso,
   output wire                          access_out,
   output wire spi_pkg::emesh_packet_t  packet_out,
   output wire                          wait_out,   // tx queue full
   output wire                          sclk,
   output wire                          mosi,
   output wire                          ss_n
   );

   import spi_pkg::*;

   spi_cfg_t    cfg;
   logic [7:0]  clkdiv;
   logic        fifo_push;
   tx_entry_t   fifo_entry;
   logic        fifo_pop;
   tx_entry_t   head_entry;
   logic        fifo_full;
   logic        fifo_empty;
   logic        start;
   tx_entry_t   start_entry;
   logic        done;
   logic        busy;
   logic        rx_access;
   logic [63:0] rx_data;
   logic        spi_en;

   assign spi_en = ~cfg.spi_off;  // enabled out of reset

   spi_master_regs #(.CLKDIV(CLKDIV)) i_regs (
      .clk, .nreset, .access_in, .packet_in, .rx_access, .rx_data, .busy, .fifo_full,
      .wait_in, .access_out, .packet_out, .wait_out, .fifo_push, .fifo_entry, .cfg, .clkdiv);

   spi_master_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
      .clk, .nreset, .push(fifo_push), .push_entry(fifo_entry), .pop(fifo_pop),
      .pop_entry(head_entry), .full(fifo_full), .empty(fifo_empty));

   spi_master_ctrl i_ctrl (
      .clk, .nreset, .spi_en, .fifo_empty, .head_entry, .done, .fifo_pop, .start,
      .start_entry, .ss_n, .busy);

   // serial engine
   spi_master_io i_io (
      .clk, .nreset, .start, .entry(start_entry), .clkdiv, .cpol(cfg.cpol), .cpha(cfg.cpha),
      .lsbfirst(cfg.lsbfirst), .miso, .sclk, .mosi, .done, .rx_access, .rx_data);

endmodule

`default_nettype wire

/* spi_master_io.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_io
   (
   input  wire                      clk,
   input  wire                      nreset,
   input  wire                      start,
   input  wire spi_pkg::tx_entry_t  entry,
   input  wire [7:0]                clkdiv,     // half period is clkdiv+1 cycles
   input  wire                      cpol,
   input  wire                      cpha,
   input  wire                      lsbfirst,
   input  wire                      miso,
   output logic                     sclk,
   output logic                     mosi,
   output logic                     done,
   output logic                     rx_access,  // pulse per received byte
   output logic [63:0]              rx_data
   );

   logic        active;
   logic [7:0]  div_cnt;
   logic        tick;       // end of a half period
   logic        sclk_int;   // 0 is idle level
   logic [3:0]  half_cnt;   // half period within byte
   logic [3:0]  half_m1;
   logic [3:0]  byte_cnt;
   logic [3:0]  nbytes;
   logic [63:0] tx_sr;      // current byte in 7:0
   logic [7:0]  rx_byte;
   logic [7:0]  rx_next;
   logic [2:0]  tx_idx;
   logic [2:0]  tx_pos;
   logic [2:0]  rx_pos;
   logic        sample;
   logic        byte_end;

   assign tick     = active && (div_cnt >= clkdiv);
   assign byte_end = tick && (half_cnt == 4'd15);
   assign sample   = tick && (half_cnt[0] == cpha);  // leading edge when cpha=0

   //############################
   // bit select
   //############################

   // cpha=1 launches on leading edges, so the bit lags one half period
   assign half_m1 = half_cnt - 4'd1;
   assign tx_idx  = cpha ? ((half_cnt == 4'd0) ? 3'd0 : half_m1[3:1]) : half_cnt[3:1];
   assign tx_pos  = lsbfirst ? tx_idx : ~tx_idx;              // ~idx is 7-idx
   assign rx_pos  = lsbfirst ? half_cnt[3:1] : ~half_cnt[3:1];

   assign mosi = active & tx_sr[tx_pos];
   assign sclk = cpol ^ sclk_int;

   always_comb
   begin
      rx_next = rx_byte;
      if (sample)
         rx_next[rx_pos] = miso;  // back into original bit place
   end

   //############################
   // counters
   //############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         active    <= 1'b0;
         div_cnt   <= '0;
         sclk_int  <= 1'b0;
         half_cnt  <= '0;
         byte_cnt  <= '0;
         done      <= 1'b0;
         rx_access <= 1'b0;
         rx_data   <= '0;
      end
      else
      begin
         done      <= 1'b0;
         rx_access <= 1'b0;
         if (start)
         begin
            active   <= 1'b1;
            div_cnt  <= '0;
            sclk_int <= 1'b0;
            half_cnt <= '0;
            byte_cnt <= '0;
         end
         else if (active)
         begin
            div_cnt <= tick ? 8'd0 : div_cnt + 8'd1;
            if (tick)
            begin
               sclk_int <= ~sclk_int;
               half_cnt <= half_cnt + 4'd1;  // wraps at byte end
            end
            if (byte_end)
            begin
               rx_access <= 1'b1;
               rx_data   <= {rx_data[55:0], rx_next};  // newest byte at bottom
               byte_cnt  <= byte_cnt + 4'd1;
               if (byte_cnt == nbytes - 4'd1)
               begin
                  active <= 1'b0;  // sclk back at idle
                  done   <= 1'b1;
               end
            end
         end
      end
   end

   // payload shift registers
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         tx_sr  <= entry.data;
         nbytes <= entry.nbytes;
      end
      else if (byte_end)
         tx_sr <= {8'b0, tx_sr[63:8]};  // next byte down
      rx_byte <= rx_next;
   end

endmodule

`default_nettype wire

/* spi_master_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_ctrl
   (
   input  wire                      clk,
   input  wire                      nreset,
   input  wire                      spi_en,
   input  wire                      fifo_empty,
   input  wire spi_pkg::tx_entry_t  head_entry,
   input  wire                      done,         // engine finished word
   output logic                     fifo_pop,
   output logic                     start,        // engine kick, one cycle
   output spi_pkg::tx_entry_t       start_entry,
   output logic                     ss_n,
   output logic                     busy
   );

   typedef enum logic [1:0] {st_idle, st_select, st_shift, st_release} state_t;

   state_t state;
   logic   hold_cnt;  // ss_n high hold after a word

   //############################
   // transfer fsm
   //############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state    <= st_idle;
         ss_n     <= 1'b1;
         start    <= 1'b0;
         hold_cnt <= 1'b0;
      end
      else
      begin
         start <= 1'b0;
         case (state)
            st_idle:
               if (spi_en && !fifo_empty)
               begin
                  ss_n  <= 1'b0;       // select slave first
                  state <= st_select;
               end
            st_select:
            begin
               start <= 1'b1;          // head popped this cycle
               state <= st_shift;
            end
            st_shift:
               if (done)
               begin
                  ss_n     <= 1'b1;
                  hold_cnt <= 1'b1;
                  state    <= st_release;
               end
            st_release:
               if (hold_cnt)
                  hold_cnt <= 1'b0;
               else
                  state <= st_idle;    // 2 cycles deselected
            default:
               state <= st_idle;
         endcase
      end
   end

   // head is captured as it leaves the queue
   always_ff @(posedge clk)
   begin
      if (state == st_select)
         start_entry <= head_entry;
   end

   assign fifo_pop = (state == st_select);
   assign busy     = (state != st_idle);

   start_selected_a : assert property (@(posedge clk) disable iff (!nreset) start |-> !ss_n)
      else $error("engine started with slave deselected");
   done_in_shift_a : assert property (@(posedge clk) disable iff (!nreset)
      done |-> (state == st_shift))
      else $error("engine done outside a transfer");

endmodule

`default_nettype wire

/* spi_master_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_fifo
  #(parameter int FIFO_DEPTH = 4)
   (
   input  wire                      clk,
   input  wire                      nreset,
   input  wire                      push,
   input  wire spi_pkg::tx_entry_t  push_entry,
   input  wire                      pop,
   output spi_pkg::tx_entry_t       pop_entry,  // head of queue
   output logic                     full,
   output logic                     empty
   );

   import spi_pkg::*;

   localparam int ptr_w = $clog2(FIFO_DEPTH);

   tx_entry_t        mem [FIFO_DEPTH];
   logic [ptr_w:0]   wr_ptr;  // msb is the wrap bit
   logic [ptr_w:0]   rd_ptr;

   //############################
   // pointers
   //############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push && !full)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop && !empty)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // storage
   always_ff @(posedge clk)
   begin
      if (push && !full)
         mem[wr_ptr[ptr_w-1:0]] <= push_entry;
   end

   assign pop_entry = mem[rd_ptr[ptr_w-1:0]];
   assign empty     = (wr_ptr == rd_ptr);
   assign full      = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                      (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);  // same slot, one lap ahead

   no_underflow_a : assert property (@(posedge clk) disable iff (!nreset) !(pop && empty))
      else $error("tx fifo pop while empty");
   no_overflow_a : assert property (@(posedge clk) disable iff (!nreset) !(push && full))
      else $error("tx fifo push while full");

endmodule

`default_nettype wire

/* spi_master_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_master_regs
  #(parameter int CLKDIV = 1)
   (
   input  wire                          clk,
   input  wire                          nreset,
   input  wire                          access_in,   // request strobe
   input  wire spi_pkg::emesh_packet_t  packet_in,
   input  wire                          rx_access,   // byte received
   input  wire [63:0]                   rx_data,
   input  wire                          busy,
   input  wire                          fifo_full,
   input  wire                          wait_in,     // core push-back, replies not held
   output logic                         access_out,  // read reply strobe
   output spi_pkg::emesh_packet_t       packet_out,
   output logic                         wait_out,
   output logic                         fifo_push,
   output spi_pkg::tx_entry_t           fifo_entry,
   output spi_pkg::spi_cfg_t            cfg,
   output logic [7:0]                   clkdiv
   );

   import spi_pkg::*;

   spi_cfg_t      config_reg;
   logic [7:0]    clkdiv_reg;
   logic [7:0]    status_reg;
   logic [63:0]   rx_reg;
   logic [aw-1:0] reg_rdata;     // registered read value
   logic [aw-1:0] dstaddr_out;
   logic [4:0]    ctrlmode_out;
   logic [1:0]    datamode_out;
   logic [5:0]    offset;
   logic          reg_write;
   logic          reg_read;
   logic          config_write;
   logic          status_write;
   logic          clkdiv_write;
   logic          tx_write;

   //############################
   // decode
   //############################

   assign offset       = packet_in.dstaddr[5:0];
   assign reg_write    = access_in & packet_in.write;
   assign reg_read     = access_in & ~packet_in.write;
   assign config_write = reg_write & (offset == spi_config);
   assign status_write = reg_write & (offset == spi_status);
   assign clkdiv_write = reg_write & (offset == spi_clkdiv);
   assign tx_write     = reg_write & (offset == spi_tx);

   //############################
   // registers
   //############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         config_reg <= '0;              // spi on by default
         clkdiv_reg <= 8'(CLKDIV);
         status_reg <= '0;
         rx_reg     <= '0;
      end
      else
      begin
         if (config_write)
            config_reg <= spi_cfg_t'(packet_in.data[7:0]);
         if (clkdiv_write)
            clkdiv_reg <= packet_in.data[7:0];
         if (status_write)
            status_reg <= packet_in.data[7:0];  // clears sticky rx flag
         else
            status_reg <= {5'b0, fifo_full, busy, rx_access | status_reg[0]};
         if (rx_access)
            rx_reg <= rx_data;           // whole shift window
      end
   end

   assign cfg    = config_reg;
   assign clkdiv = clkdiv_reg;

   // tx queue push, dropped when full
   assign fifo_push         = tx_write & ~fifo_full;
   assign fifo_entry.nbytes = mode_nbytes(packet_in.datamode);
   assign fifo_entry.data   = {(packet_in.datamode == 2'd3) ? packet_in.hi.data_hi : 32'b0,
                               packet_in.data};
   assign wait_out          = fifo_full;

   //############################
   // readback
   //############################

   always_ff @(posedge clk)
   begin
      if (reg_read)
      begin
         case (offset)
            spi_config: reg_rdata <= {24'b0, config_reg};
            spi_status: reg_rdata <= {24'b0, status_reg};
            spi_clkdiv: reg_rdata <= {24'b0, clkdiv_reg};
            spi_rx0:    reg_rdata <= rx_reg[31:0];
            spi_rx1:    reg_rdata <= rx_reg[63:32];
            default:    reg_rdata <= read_filler;
         endcase
      end
      dstaddr_out  <= packet_in.hi.srcaddr;  // reply goes back to source
      ctrlmode_out <= packet_in.ctrlmode;
      datamode_out <= packet_in.datamode;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         access_out <= 1'b0;
      else
         access_out <= reg_read;  // reads only
   end

   always_comb
   begin
      packet_out.write      = 1'b1;
      packet_out.datamode   = datamode_out;
      packet_out.ctrlmode   = ctrlmode_out;
      packet_out.dstaddr    = dstaddr_out;
      packet_out.hi.srcaddr = '0;
      packet_out.data       = reg_rdata;
   end

   // core must honor wait_out before queueing tx data
   tx_overflow_a : assert property (@(posedge clk) disable iff (!nreset)
      !(tx_write && fifo_full))
      else $error("spi tx write while fifo full");

endmodule

`default_nettype wire

/* spi_pkg.sv */
`default_nettype none

package spi_pkg;

   localparam int aw = 32;  // address and data width

   //############################
   // register map
   //############################

   // offsets within dstaddr[5:0]
   localparam logic [5:0] spi_config = 6'h00;
   localparam logic [5:0] spi_status = 6'h04;
   localparam logic [5:0] spi_clkdiv = 6'h08;
   localparam logic [5:0] spi_tx     = 6'h10;
   localparam logic [5:0] spi_rx0    = 6'h20;  // rx bits 31:0
   localparam logic [5:0] spi_rx1    = 6'h24;  // rx bits 63:32

   localparam logic [aw-1:0] read_filler = 32'hDEADBEEF;  // unmapped reads

   //############################
   // packet types
   //############################

   // upper packet word
   typedef union packed {
      logic [aw-1:0] srcaddr;  // where the read reply goes
      logic [aw-1:0] data_hi;  // tx bytes 7 to 4 on 64-bit writes
   } emesh_hi_t;

   typedef struct packed {
      logic          write;
      logic [1:0]    datamode;  // 0=byte 1=half 2=word 3=double
      logic [4:0]    ctrlmode;
      logic [aw-1:0] dstaddr;
      emesh_hi_t     hi;
      logic [aw-1:0] data;
   } emesh_packet_t;

   // config register, bit 0 upward
   typedef struct packed {
      logic [3:0] rsvd;
      logic       lsbfirst;  // bit 3
      logic       cpha;      // bit 2
      logic       cpol;      // bit 1
      logic       spi_off;   // bit 0, set stops new transfers
   } spi_cfg_t;

   // one queued transmit word
   typedef struct packed {
      logic [3:0]  nbytes;  // 1 to 8
      logic [63:0] data;    // byte 0 goes out first
   } tx_entry_t;

   // byte count for a tx write of the given datamode
   function automatic logic [3:0] mode_nbytes(input logic [1:0] datamode);
      case (datamode)
         2'd0:    return 4'd1;
         2'd1:    return 4'd2;
         2'd2:    return 4'd4;
         default: return 4'd8;
      endcase
   endfunction

endpackage

`default_nettype wire
